// ==== include/tap_defines.svh ====
// JTAG TAP controller constants
// Register widths, instruction codes and DMI chain identifiers

`ifndef TAP_DEFINES_SVH
`define TAP_DEFINES_SVH

// ------------------------------------------------
// Register widths
// ------------------------------------------------
`define TAP_IR_WIDTH            5       // Instruction register
`define TAP_IDCODE_WIDTH        32      // IDCODE data register
`define TAP_BYPASS_WIDTH        1       // BYPASS data register
`define TAP_DMI_CH_ID_WIDTH     2       // DMI chain identifier

// ------------------------------------------------
// Instruction codes
// ------------------------------------------------
`define TAP_INSTR_IDCODE        5'h01   // Also the IR value after reset
`define TAP_INSTR_DTMCS         5'h10   // Debug transport control/status
`define TAP_INSTR_DMI_ACCESS    5'h11   // Debug module interface access
`define TAP_INSTR_BYPASS        5'h1F   // All ones, per 1149.1

// ------------------------------------------------
// DMI scan-chain identifiers
// ------------------------------------------------
`define TAP_DMI_CH_DTMCS        2'd1
`define TAP_DMI_CH_DMI          2'd2

`endif

// ==== hdl/tap_pkg.sv ====
// Shared types for the JTAG TAP controller
// TAP state encoding and vector typedefs

`default_nettype none

`include "tap_defines.svh"

package tap_pkg;

    // ------------------------------------------------
    // TAP state machine, IEEE 1149.1 sixteen states
    // ------------------------------------------------
    typedef enum logic [3:0] {
        RESET      = 4'h0,  // Test-Logic-Reset
        IDLE       = 4'h1,  // Run-Test/Idle
        DR_SELECT  = 4'h2,
        DR_CAPTURE = 4'h3,
        DR_SHIFT   = 4'h4,
        DR_EXIT1   = 4'h5,
        DR_PAUSE   = 4'h6,
        DR_EXIT2   = 4'h7,
        DR_UPDATE  = 4'h8,
        IR_SELECT  = 4'h9,
        IR_CAPTURE = 4'hA,
        IR_SHIFT   = 4'hB,
        IR_EXIT1   = 4'hC,
        IR_PAUSE   = 4'hD,
        IR_EXIT2   = 4'hE,
        IR_UPDATE  = 4'hF
    } tap_state_e;

    // ------------------------------------------------
    // Vectors with a meaning
    // ------------------------------------------------
    typedef logic [`TAP_IR_WIDTH-1:0]        tap_ir_t;      // Instruction code
    typedef logic [`TAP_IDCODE_WIDTH-1:0]    tap_idcode_t;  // Device IDCODE
    typedef logic [`TAP_DMI_CH_ID_WIDTH-1:0] dmi_ch_id_t;   // DMI chain number

endpackage

`default_nettype wire

// ==== hdl/tap_fsm.sv ====
// TAP state machine driven by TMS
// Logic reset from Test-Logic-Reset, state decodes, registered DR/IR strobes

`timescale 1ns/1ps
`default_nettype none

module tap_fsm (
    input  logic tck,
    input  logic trst_n,
    input  logic tms,
    output logic tap_rst_n,       // Logic reset, low in Test-Logic-Reset
    output logic in_ir_capture,   // State decodes for the IR
    output logic in_ir_shift,
    output logic in_ir_update,
    output logic ir_shift,        // Registered strobes
    output logic dr_capture,
    output logic dr_shift,
    output logic dr_update
);

    tap_pkg::tap_state_e state;
    tap_pkg::tap_state_e state_nxt;

    // ------------------------------------------------
    // State register and TMS transitions
    // ------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            state <= tap_pkg::RESET;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            tap_pkg::RESET:      state_nxt = tms ? tap_pkg::RESET     : tap_pkg::IDLE;
            tap_pkg::IDLE:       state_nxt = tms ? tap_pkg::DR_SELECT : tap_pkg::IDLE;
            tap_pkg::DR_SELECT:  state_nxt = tms ? tap_pkg::IR_SELECT : tap_pkg::DR_CAPTURE;
            tap_pkg::DR_CAPTURE: state_nxt = tms ? tap_pkg::DR_EXIT1  : tap_pkg::DR_SHIFT;
            tap_pkg::DR_SHIFT:   state_nxt = tms ? tap_pkg::DR_EXIT1  : tap_pkg::DR_SHIFT;
            tap_pkg::DR_EXIT1:   state_nxt = tms ? tap_pkg::DR_UPDATE : tap_pkg::DR_PAUSE;
            tap_pkg::DR_PAUSE:   state_nxt = tms ? tap_pkg::DR_EXIT2  : tap_pkg::DR_PAUSE;
            tap_pkg::DR_EXIT2:   state_nxt = tms ? tap_pkg::DR_UPDATE : tap_pkg::DR_SHIFT;
            tap_pkg::DR_UPDATE:  state_nxt = tms ? tap_pkg::DR_SELECT : tap_pkg::IDLE;
            tap_pkg::IR_SELECT:  state_nxt = tms ? tap_pkg::RESET     : tap_pkg::IR_CAPTURE;
            tap_pkg::IR_CAPTURE: state_nxt = tms ? tap_pkg::IR_EXIT1  : tap_pkg::IR_SHIFT;
            tap_pkg::IR_SHIFT:   state_nxt = tms ? tap_pkg::IR_EXIT1  : tap_pkg::IR_SHIFT;
            tap_pkg::IR_EXIT1:   state_nxt = tms ? tap_pkg::IR_UPDATE : tap_pkg::IR_PAUSE;
            tap_pkg::IR_PAUSE:   state_nxt = tms ? tap_pkg::IR_EXIT2  : tap_pkg::IR_PAUSE;
            tap_pkg::IR_EXIT2:   state_nxt = tms ? tap_pkg::IR_UPDATE : tap_pkg::IR_SHIFT;
            tap_pkg::IR_UPDATE:  state_nxt = tms ? tap_pkg::DR_SELECT : tap_pkg::IDLE;
            default:             state_nxt = tap_pkg::RESET;
        endcase
    end

    // ------------------------------------------------
    // Logic reset, half a cycle behind the state
    // ------------------------------------------------
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tap_rst_n <= 1'b0;
        end else begin
            tap_rst_n <= (state != tap_pkg::RESET);
        end
    end

    // Current-state decodes used by the IR
    assign in_ir_capture = (state == tap_pkg::IR_CAPTURE);
    assign in_ir_shift   = (state == tap_pkg::IR_SHIFT);
    assign in_ir_update  = (state == tap_pkg::IR_UPDATE);

    // ------------------------------------------------
    // Strobes, set on the edge that enters the state
    // ------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_shift   <= 1'b0;
            dr_capture <= 1'b0;
            dr_shift   <= 1'b0;
            dr_update  <= 1'b0;
        end else begin
            // Next state is Shift-IR
            ir_shift   <= (state_nxt == tap_pkg::IR_SHIFT) & tap_rst_n;
            dr_capture <= (state_nxt == tap_pkg::DR_CAPTURE) & tap_rst_n;
            dr_shift   <= (state_nxt == tap_pkg::DR_SHIFT) & tap_rst_n;
            dr_update  <= (state_nxt == tap_pkg::DR_UPDATE) & tap_rst_n;  // One cycle pulse
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tap_ir.sv ====
// TAP instruction register
// Shift part on the rising edge, update part on the falling edge

`timescale 1ns/1ps
`default_nettype none

`include "tap_defines.svh"

module tap_ir (
    input  logic             tck,
    input  logic             trst_n,
    input  logic             tap_rst_n,      // Logic reset from the FSM
    input  logic             tdi,
    input  logic             in_ir_capture,  // Current state is Capture-IR
    input  logic             in_ir_shift,    // Current state is Shift-IR
    input  logic             in_ir_update,   // Current state is Update-IR
    output tap_pkg::tap_ir_t ir,             // Active instruction
    output logic             ir_tdo          // Serial out of the shift part
);

    tap_pkg::tap_ir_t ir_shift_reg;

    // ------------------------------------------------
    // Shift part
    // ------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_shift_reg <= '0;
        end else if (!tap_rst_n) begin
            ir_shift_reg <= '0;
        end else if (in_ir_capture) begin
            // Fixed capture pattern, LSB must read 1
            ir_shift_reg <= tap_pkg::tap_ir_t'(1);
        end else if (in_ir_shift) begin
            ir_shift_reg <= {tdi, ir_shift_reg[`TAP_IR_WIDTH-1:1]};  // LSB out first
        end
    end

    assign ir_tdo = ir_shift_reg[0];

    // ------------------------------------------------
    // Update part
    // ------------------------------------------------
    // Loads mid-cycle in Update-IR so decode is stable
    // before the next rising edge
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir <= `TAP_INSTR_IDCODE;
        end else if (!tap_rst_n) begin
            ir <= `TAP_INSTR_IDCODE;      // Back to IDCODE in Test-Logic-Reset
        end else if (in_ir_update) begin
            ir <= ir_shift_reg;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tap_data_regs.sv ====
// TAP data registers
// Instruction decode, IDCODE and BYPASS shift registers, DR serial output select

`timescale 1ns/1ps
`default_nettype none

`include "tap_defines.svh"

module tap_data_regs (
    input  logic                  tck,
    input  logic                  trst_n,
    input  logic                  tap_rst_n,
    input  logic                  tdi,
    input  logic                  dr_capture,   // High in Capture-DR
    input  logic                  dr_shift,     // High in Shift-DR
    input  logic                  dmi_ch_tdo,   // Serial return from DMI side
    input  tap_pkg::tap_ir_t      ir,
    input  tap_pkg::tap_idcode_t  fuse_idcode,
    output logic                  dr_tdo,
    output logic                  dmi_ch_sel,
    output tap_pkg::dmi_ch_id_t   dmi_ch_id
);

    logic                          idcode_sel;
    logic                          bypass_sel;
    tap_pkg::tap_idcode_t          idcode_reg;
    logic [`TAP_BYPASS_WIDTH-1:0]  bypass_reg;
    logic [`TAP_BYPASS_WIDTH:0]    bypass_nxt;   // tdi prepended for the shift

    // ------------------------------------------------
    // Instruction decode and DR output select
    // ------------------------------------------------
    always_comb begin
        idcode_sel = 1'b0;
        bypass_sel = 1'b0;
        dmi_ch_sel = 1'b0;
        dmi_ch_id  = '0;
        dr_tdo     = 1'b0;
        case (ir)
            `TAP_INSTR_IDCODE: begin
                idcode_sel = 1'b1;
                dr_tdo     = idcode_reg[0];
            end
            `TAP_INSTR_DTMCS: begin
                dmi_ch_sel = 1'b1;
                dmi_ch_id  = `TAP_DMI_CH_DTMCS;
                dr_tdo     = dmi_ch_tdo;         // Chain lives outside
            end
            `TAP_INSTR_DMI_ACCESS: begin
                dmi_ch_sel = 1'b1;
                dmi_ch_id  = `TAP_DMI_CH_DMI;
                dr_tdo     = dmi_ch_tdo;
            end
            default: begin
                // BYPASS and every undecoded code
                bypass_sel = 1'b1;
                dr_tdo     = bypass_reg[0];
            end
        endcase
    end

    // ------------------------------------------------
    // IDCODE register
    // ------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            idcode_reg <= '0;
        end else if (!tap_rst_n) begin
            idcode_reg <= '0;
        end else if (idcode_sel && dr_capture) begin
            idcode_reg <= fuse_idcode;           // Sampled from fuses
        end else if (idcode_sel && dr_shift) begin
            idcode_reg <= {tdi, idcode_reg[`TAP_IDCODE_WIDTH-1:1]};
        end
    end

    // ------------------------------------------------
    // BYPASS register
    // ------------------------------------------------
    assign bypass_nxt = {tdi, bypass_reg};

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            bypass_reg <= '0;
        end else if (!tap_rst_n) begin
            bypass_reg <= '0;
        end else if (bypass_sel && dr_capture) begin
            bypass_reg <= '0;                    // Captures zero
        end else if (bypass_sel && dr_shift) begin
            bypass_reg <= bypass_nxt[`TAP_BYPASS_WIDTH:1];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tap_tdo_out.sv ====
// TDO source select and falling-edge output registers

`timescale 1ns/1ps
`default_nettype none

module tap_tdo_out (
    input  logic tck,
    input  logic trst_n,
    input  logic tap_rst_n,
    input  logic dr_shift,
    input  logic ir_shift,
    input  logic dr_tdo,     // Selected data register LSB
    input  logic ir_tdo,     // IR shift part LSB
    output logic tdo,
    output logic tdo_en      // Pad output enable
);

    logic tdo_mux;
    logic tdo_en_mux;

    // DR shift wins, the two never overlap anyway
    always_comb begin
        tdo_mux    = 1'b0;
        tdo_en_mux = dr_shift | ir_shift;
        if (dr_shift) begin
            tdo_mux = dr_tdo;
        end else if (ir_shift) begin
            tdo_mux = ir_tdo;
        end
    end

    // ------------------------------------------------
    // Output registers on the falling edge
    // ------------------------------------------------
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else if (!tap_rst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo    <= tdo_mux;     // Stable for the next rising edge
            tdo_en <= tdo_en_mux;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tap_ctrl_top.sv ====
// JTAG TAP controller top level
// State machine, instruction register, data registers and TDO stage

`timescale 1ns/1ps
`default_nettype none

module tap_ctrl_top (
    // JTAG pins
    input  logic                 tck,
    input  logic                 trst_n,
    input  logic                 tms,
    input  logic                 tdi,
    output logic                 tdo,
    output logic                 tdo_en,
    input  tap_pkg::tap_idcode_t fuse_idcode,   // IDCODE value from fuses
    // DMI scan-chain port
    output logic                 dmi_ch_sel,
    output tap_pkg::dmi_ch_id_t  dmi_ch_id,
    output logic                 dmi_ch_capture,
    output logic                 dmi_ch_shift,
    output logic                 dmi_ch_update,
    output logic                 dmi_ch_tdi,
    input  logic                 dmi_ch_tdo
);

    logic             tap_rst_n;
    logic             in_ir_capture;
    logic             in_ir_shift;
    logic             in_ir_update;
    logic             ir_shift;
    logic             dr_capture;
    logic             dr_shift;
    logic             dr_update;
    tap_pkg::tap_ir_t ir;
    logic             ir_tdo;
    logic             dr_tdo;

    tap_fsm u_fsm (
        .tck(tck), .trst_n(trst_n), .tms(tms), .tap_rst_n(tap_rst_n),
        .in_ir_capture(in_ir_capture), .in_ir_shift(in_ir_shift),
        .in_ir_update(in_ir_update), .ir_shift(ir_shift),
        .dr_capture(dr_capture), .dr_shift(dr_shift), .dr_update(dr_update)
    );

    tap_ir u_ir (
        .tck(tck), .trst_n(trst_n), .tap_rst_n(tap_rst_n), .tdi(tdi),
        .in_ir_capture(in_ir_capture), .in_ir_shift(in_ir_shift),
        .in_ir_update(in_ir_update), .ir(ir), .ir_tdo(ir_tdo)
    );

    tap_data_regs u_data_regs (
        .tck(tck), .trst_n(trst_n), .tap_rst_n(tap_rst_n), .tdi(tdi),
        .dr_capture(dr_capture), .dr_shift(dr_shift), .dmi_ch_tdo(dmi_ch_tdo),
        .ir(ir), .fuse_idcode(fuse_idcode), .dr_tdo(dr_tdo),
        .dmi_ch_sel(dmi_ch_sel), .dmi_ch_id(dmi_ch_id)
    );

    tap_tdo_out u_tdo_out (
        .tck(tck), .trst_n(trst_n), .tap_rst_n(tap_rst_n),
        .dr_shift(dr_shift), .ir_shift(ir_shift),
        .dr_tdo(dr_tdo), .ir_tdo(ir_tdo), .tdo(tdo), .tdo_en(tdo_en)
    );

    // DMI chain strobes come straight from the FSM
    assign dmi_ch_capture = dr_capture;
    assign dmi_ch_shift   = dr_shift;
    assign dmi_ch_update  = dr_update;
    assign dmi_ch_tdi     = tdi;

endmodule

`default_nettype wire

// ==== testbench/tb_tap_ctrl.sv ====
// Testbench for the JTAG TAP controller
// Table of IR and DR scans, DMI chain model, LFSR stimulus, checker, watchdog

`timescale 1ns/1ps
`default_nettype none

`include "tap_defines.svh"

module tb_tap_ctrl;

    localparam int         CLK_HALF_NS     = 20;
    localparam int         TABLE_LEN       = 6;
    localparam int         WATCHDOG_CYCLES = TABLE_LEN * 200;
    localparam logic [3:0] DMI_CAPTURE_VAL = 4'hB;     // Loaded by the chain model

    // Expected data register selection
    localparam logic [1:0] KIND_IDCODE = 2'd0;
    localparam logic [1:0] KIND_BYPASS = 2'd1;
    localparam logic [1:0] KIND_DMI    = 2'd2;

    typedef struct packed {
        logic [`TAP_IR_WIDTH-1:0] instr;
        logic [7:0]               dr_len;   // Bits shifted in the DR scan
        logic [1:0]               kind;
        logic [1:0]               ch_id;    // Expected dmi_ch_id
    } entry_t;

    localparam entry_t TEST_TABLE [0:TABLE_LEN-1] = '{
        '{`TAP_INSTR_IDCODE,     8'd32, KIND_IDCODE, 2'd0},
        '{`TAP_INSTR_BYPASS,     8'd12, KIND_BYPASS, 2'd0},
        '{5'h05,                 8'd12, KIND_BYPASS, 2'd0},   // Undecoded code
        '{`TAP_INSTR_DTMCS,      8'd8,  KIND_DMI,    2'd1},
        '{`TAP_INSTR_DMI_ACCESS, 8'd8,  KIND_DMI,    2'd2},
        '{`TAP_INSTR_IDCODE,     8'd40, KIND_IDCODE, 2'd0}    // tdi shows after 32 bits
    };

    // DUT pins
    logic                 tck = 1'b0;
    logic                 trst_n;
    logic                 tms;
    logic                 tdi;
    logic                 dmi_ch_tdo;
    tap_pkg::tap_idcode_t fuse_idcode;
    logic                 tdo;
    logic                 tdo_en;
    logic                 dmi_ch_sel;
    tap_pkg::dmi_ch_id_t  dmi_ch_id;
    logic                 dmi_ch_capture;
    logic                 dmi_ch_shift;
    logic                 dmi_ch_update;
    logic                 dmi_ch_tdi;

    logic [31:0] lfsr_state;
    logic [31:0] fuse_val;      // Copy of the IDCODE driven on the fuses
    logic [3:0]  dmi_chain;
    int          capture_cnt;
    int          shift_cnt;
    int          update_cnt;
    int          error_cnt;
    int          test_cnt;
    int          test_fail_cnt;

    always #(CLK_HALF_NS) tck = ~tck;

    tap_ctrl_top u_dut (
        .tck(tck), .trst_n(trst_n), .tms(tms), .tdi(tdi),
        .tdo(tdo), .tdo_en(tdo_en), .fuse_idcode(fuse_idcode),
        .dmi_ch_sel(dmi_ch_sel), .dmi_ch_id(dmi_ch_id),
        .dmi_ch_capture(dmi_ch_capture), .dmi_ch_shift(dmi_ch_shift),
        .dmi_ch_update(dmi_ch_update), .dmi_ch_tdi(dmi_ch_tdi),
        .dmi_ch_tdo(dmi_ch_tdo)
    );

    // ------------------------------------------------
    // DMI chain model and strobe counters
    // ------------------------------------------------
    always @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            dmi_chain <= '0;
        end else if (dmi_ch_sel && dmi_ch_capture) begin
            dmi_chain <= DMI_CAPTURE_VAL;
        end else if (dmi_ch_sel && dmi_ch_shift) begin
            dmi_chain <= {dmi_ch_tdi, dmi_chain[3:1]};    // LSB leaves first
        end
    end

    assign dmi_ch_tdo = dmi_chain[0];

    // Strobes settle after the rising edge, count them mid-cycle
    always @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            capture_cnt <= 0;
            shift_cnt   <= 0;
            update_cnt  <= 0;
        end else begin
            if (dmi_ch_capture) begin
                capture_cnt <= capture_cnt + 1;
            end
            if (dmi_ch_shift) begin
                shift_cnt <= shift_cnt + 1;
            end
            if (dmi_ch_update) begin
                update_cnt <= update_cnt + 1;
            end
        end
    end

    // ------------------------------------------------
    // Stimulus and checking helpers
    // ------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            error_cnt++;
        end
    endtask

    // One TCK cycle; called just after a rising edge, samples at the next one
    task automatic tck_cycle(input logic tms_v, input logic tdi_v,
                             output logic tdo_v, output logic tdo_en_v);
        tms <= tms_v;
        tdi <= tdi_v;
        @(posedge tck);
        tdo_v    = tdo;
        tdo_en_v = tdo_en;
    endtask

    // TMS bits applied LSB first, TDO must stay disabled
    task automatic walk_tms(input logic [7:0] pattern, input int count);
        logic tdo_v;
        logic en_v;
        for (int i = 0; i < count; i++) begin
            tck_cycle(pattern[i], 1'b0, tdo_v, en_v);
            check_value("tdo_en", 64'd0, 64'(en_v));
        end
    endtask

    task automatic enter_shift_dr();
        walk_tms(8'b0000_0001, 3);      // Select-DR, Capture-DR, Shift-DR
    endtask

    task automatic enter_shift_ir();
        walk_tms(8'b0000_0011, 4);      // through Select-IR
    endtask

    task automatic exit_to_idle();
        walk_tms(8'b0000_0001, 2);      // Exit1 -> Update -> Idle
    endtask

    // Last bit goes out with TMS high, into Exit1
    task automatic scan_bits(input int n, input logic [63:0] din, output logic [63:0] dout);
        logic tdo_v;
        logic en_v;
        dout = '0;
        for (int i = 0; i < n; i++) begin
            tck_cycle((i == n - 1), din[i], tdo_v, en_v);
            dout[i] = tdo_v;
            check_value("tdo_en", 64'd1, 64'(en_v));
        end
    endtask

    // Captured bits first, then the tdi stream delayed by the register length
    function automatic logic [63:0] expected_stream(input logic [63:0] cap_val,
                                                    input int reg_len,
                                                    input logic [63:0] din, input int n);
        logic [63:0] exp_v;
        exp_v = '0;
        for (int i = 0; i < n; i++) begin
            if (i < reg_len) begin
                exp_v[i] = cap_val[i];
            end else begin
                exp_v[i] = din[i - reg_len];
            end
        end
        return exp_v;
    endfunction

    task automatic load_instr(input logic [`TAP_IR_WIDTH-1:0] code);
        logic [63:0] dout;
        enter_shift_ir();
        scan_bits(`TAP_IR_WIDTH, 64'(code), dout);
        check_value("ir capture", 64'h01, dout);  // Pattern 00001
        exit_to_idle();
    endtask

    task automatic run_dr_scan(input int n, input int reg_len, input logic [63:0] cap_val);
        logic [63:0] din;
        logic [63:0] dout;
        int          cap0;
        int          shift0;
        int          upd0;
        random_bits(n, din);
        cap0   = capture_cnt;
        shift0 = shift_cnt;
        upd0   = update_cnt;
        enter_shift_dr();
        scan_bits(n, din, dout);
        exit_to_idle();
        check_value("tdo", expected_stream(cap_val, reg_len, din, n), dout);
        check_value("dmi_ch_capture count", 64'd1, 64'(capture_cnt - cap0));
        check_value("dmi_ch_shift count", 64'(n), 64'(shift_cnt - shift0));
        check_value("dmi_ch_update count", 64'd1, 64'(update_cnt - upd0));
    endtask

    task automatic report_test(input string name, input int err0);
        test_cnt++;
        if (error_cnt == err0) begin
            $display("Test %0d, %s: ok", test_cnt, name);
        end else begin
            test_fail_cnt++;
            $display("Test %0d, %s: FAILED, %0d mismatches", test_cnt, name,
                     error_cnt - err0);
        end
    endtask

    task automatic run_entry(input int idx);
        entry_t      e;
        int          reg_len;
        logic [63:0] cap_val;
        int          err0;
        e    = TEST_TABLE[idx];
        err0 = error_cnt;
        load_instr(e.instr);
        check_value("dmi_ch_sel", 64'(e.kind == KIND_DMI), 64'(dmi_ch_sel));
        check_value("dmi_ch_id", 64'(e.ch_id), 64'(dmi_ch_id));
        case (e.kind)
            KIND_IDCODE: begin
                reg_len = 32;
                cap_val = 64'(fuse_val);
            end
            KIND_BYPASS: begin
                reg_len = 1;
                cap_val = '0;               // BYPASS captures zero
            end
            default: begin
                reg_len = 4;
                cap_val = 64'(DMI_CAPTURE_VAL);
            end
        endcase
        run_dr_scan(int'(e.dr_len), reg_len, cap_val);
        report_test($sformatf("entry %0d, instr %h", idx, e.instr), err0);
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        logic [63:0] rnd;
        int          err0;
        lfsr_state    = 32'h4531;
        error_cnt     = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        trst_n        = 1'b0;
        tms           = 1'b1;
        tdi           = 1'b0;
        random_bits(32, rnd);
        fuse_val      = rnd[31:0];
        fuse_idcode   = fuse_val;

        repeat (2) @(posedge tck);
        trst_n <= 1'b1;

        // Reset values, then IDCODE with no IR scan
        err0 = error_cnt;
        check_value("tdo", 64'd0, 64'(tdo));
        check_value("tdo_en", 64'd0, 64'(tdo_en));
        check_value("dmi_ch_sel", 64'd0, 64'(dmi_ch_sel));
        check_value("dmi_ch_capture", 64'd0, 64'(dmi_ch_capture));
        check_value("dmi_ch_shift", 64'd0, 64'(dmi_ch_shift));
        check_value("dmi_ch_update", 64'd0, 64'(dmi_ch_update));
        walk_tms(8'b0000_0000, 1);                 // to Idle
        run_dr_scan(32, 32, 64'(fuse_val));
        report_test("reset state and IDCODE scan", err0);

        for (int idx = 0; idx < TABLE_LEN; idx++) begin
            run_entry(idx);
        end

        // TMS reset drops a DMI instruction back to IDCODE
        err0 = error_cnt;
        load_instr(`TAP_INSTR_DTMCS);
        check_value("dmi_ch_sel", 64'd1, 64'(dmi_ch_sel));
        walk_tms(8'b0001_1111, 5);
        walk_tms(8'b0000_0000, 1);
        check_value("dmi_ch_sel", 64'd0, 64'(dmi_ch_sel));
        random_bits(32, rnd);
        fuse_val    = rnd[31:0];
        fuse_idcode <= fuse_val;                  // New value must be recaptured
        run_dr_scan(32, 32, 64'(fuse_val));
        report_test("TMS reset back to IDCODE", err0);

        $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                 test_cnt, test_fail_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog, scaled to the table length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge tck);
        $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
hdl/tap_pkg.sv
hdl/tap_fsm.sv
hdl/tap_ir.sv
hdl/tap_data_regs.sv
hdl/tap_tdo_out.sv
hdl/tap_ctrl_top.sv
testbench/tb_tap_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the TAP controller testbench with Verilator and run it.
# The run passes only if the simulation output holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_tap_ctrl -Mdir obj_dir \
    && ./obj_dir/Vtb_tap_ctrl | tee /dev/stderr | grep -qF 'All tests passed!' \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

exit 0
